//--- dv/dbg_testdata.hex
// Word 0: run length in cycles before halt. Words 1-32: registers 0 to 31.
// Words 33 on: program words, closed by the HALT word FFFFFFFF.
@0
0000000C
00000000 11223344 0801080B A5A55A5A
DEADBEEF 00000008 7F00FF01 12345678
CAFEF00D 0000000B 80000000 00000001
13579BDF 2468ACE0 FEDCBA98 01020304
0F0F0F0F F0F0F0F0 55AA55AA 00FF00FF
ABCDEF01 10203040 99887766 07030100
C0FFEE00 BADC0DE5 00000003 FFFFFFFE
6B8B4567 327B23C6 643C9869 66334873
20080005 2009000A 01095020 AC0A0000
8C0B0000 FFFFFF00
FFFFFFFF

//--- filelist.f
hdl/dbg_pkg.sv
hdl/rx_byte_if.sv
hdl/dbg_cmd_decoder.sv
hdl/dbg_program_loader.sv
hdl/dbg_reg_dump.sv
hdl/dbg_control_fsm.sv
hdl/dbg_top.sv
dv/tb_dbg_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the debug unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dbg_top -f filelist.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- dv/tb_dbg_top.sv
`default_nettype none

module tb_dbg_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] HALT   = 32'hFFFF_FFFF;
    localparam logic [7:0]  READY  = 8'h01;
    localparam logic [7:0]  ENDB   = 8'h0B;
    localparam logic [7:0]  C_RST  = 8'h00;
    localparam logic [7:0]  C_LOAD = 8'h01;
    localparam logic [7:0]  C_RUN  = 8'h03;
    localparam logic [7:0]  C_STEP = 8'h07;
    localparam logic [7:0]  C_ACK  = 8'h08;

    logic        clock, reset, rx_done, soft_reset_ack, halt;
    logic [7:0]  rx_data;
    logic [31:0] reg_data = '0;
    wire         tx_start, soft_reset_n, prog_write, cpu_enable;
    wire  [7:0]  tx_data;
    wire  [9:0]  prog_addr;
    wire  [31:0] prog_data;
    wire  [4:0]  reg_addr;

    logic [31:0] tdata [0:63];   // Run length, 32 registers, program.
    logic [31:0] regs [0:31];
    logic [31:0] prog [$];
    int          run_len, errors, checks, test_err;
    int          writes, load_base, cycles, limit;
    int          enable_cycles;  // Processor enable cycles seen.
    logic [15:0] lfsr;

    dbg_top i_dbg_top (
        .i_clock(clock), .i_reset(reset), .i_rx_done(rx_done), .i_rx_data(rx_data),
        .i_soft_reset_ack(soft_reset_ack), .i_halt(halt), .i_reg_data(reg_data),
        .o_tx_start(tx_start), .o_tx_data(tx_data), .o_soft_reset_n(soft_reset_n),
        .o_prog_write(prog_write), .o_prog_addr(prog_addr), .o_prog_data(prog_data),
        .o_cpu_enable(cpu_enable), .o_reg_addr(reg_addr)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period.
    end

    always @(negedge clock) reg_data <= regs[reg_addr];  // Register-file model.

    always @(posedge clock) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the DUT stopped responding after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Program memory write monitor.
    always @(negedge clock) begin
        if (prog_write) begin
            check_value("write address", 32'(prog_addr), 32'(writes - load_base));
            check_value("write not HALT", 32'(prog_data == HALT), 32'd0);
            if (writes - load_base < prog.size()) begin
                check_value("write data", prog_data, prog[writes - load_base]);
            end
            writes++;
        end
    end

    always @(negedge clock) begin
        if (cpu_enable) begin
            enable_cycles++;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Galois LFSR stepped once per bit taken.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx_data = b;
        rx_done = 1'b1;
        repeat (3) @(negedge clock);
        rx_done = 1'b0;
        repeat (4) @(negedge clock);  // Strobe is consumed by now.
    endtask

    task automatic ack_byte();
        int d;
        take_bits(4, d);
        repeat (d) @(negedge clock);
        send_byte(C_ACK);
    endtask

    task automatic finish_test(input string name);
        $display("Test %s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    task automatic soft_reset();
        send_byte(C_RST);
        while (soft_reset_n) @(negedge clock);
        repeat (5) begin
            check_value("soft reset held", 32'(soft_reset_n), 32'd0);
            @(negedge clock);
        end
        soft_reset_ack = 1'b0;
        while (!tx_start) @(negedge clock);
        check_value("soft reset released", 32'(soft_reset_n), 32'd1);
        check_value("ready byte", 32'(tx_data), 32'(READY));
        soft_reset_ack = 1'b1;
    endtask

    task automatic load_program();
        logic [31:0] w;
        load_base = writes;
        send_byte(C_LOAD);
        for (int i = 0; i <= prog.size(); i++) begin
            w = (i < prog.size()) ? prog[i] : HALT;
            for (int b = 3; b >= 0; b--) begin
                send_byte(w[8*b +: 8]);
            end
        end
        repeat (4) @(negedge clock);
        check_value("write count", 32'(writes - load_base), 32'(prog.size()));
    endtask

    task automatic check_dump();
        while (!tx_start) @(negedge clock);
        @(negedge clock);
        for (int r = 0; r < 32; r++) begin
            for (int b = 3; b >= 0; b--) begin
                check_value("dump valid", 32'(tx_start), 32'd1);
                check_value("reg address", 32'(reg_addr), 32'(r));
                check_value($sformatf("reg %0d byte %0d", r, b), 32'(tx_data),
                            32'(regs[r][8*b +: 8]));
                ack_byte();
            end
        end
        check_value("end byte", 32'(tx_data), 32'(ENDB));
        ack_byte();
        check_value("dump released", 32'(tx_start), 32'd0);
    endtask

    initial begin
        int n;
        reset = 1'b0;
        rx_done = 1'b0;
        rx_data = '0;
        soft_reset_ack = 1'b1;
        halt = 1'b0;
        lfsr = 16'd4786;
        errors = 0;
        checks = 0;
        test_err = 0;
        writes = 0;
        load_base = 0;
        cycles = 0;
        limit = 0;
        enable_cycles = 0;
        $readmemh("dv/dbg_testdata.hex", tdata);
        run_len = int'(tdata[0]);
        for (int i = 0; i < 32; i++) begin
            regs[i] = tdata[i + 1];
        end
        n = 33;
        while (n < 64 && tdata[n] !== HALT) begin
            prog.push_back(tdata[n]);
            n++;
        end
        if (n == 64) begin
            $display("Test data has no HALT word, nothing can be loaded");
            $display("TESTBENCH FAILED");
            $finish;
        end
        // Three dumps, two ready bytes, two loads and the run.
        limit = (40 * (3 * 129 + 2 + 8 * (prog.size() + 1) + 10) + run_len) * 2;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        check_value("tx_start", 32'(tx_start), 32'd0);
        check_value("prog_write", 32'(prog_write), 32'd0);
        check_value("cpu_enable", 32'(cpu_enable), 32'd0);
        check_value("soft_reset_n", 32'(soft_reset_n), 32'd1);
        finish_test("reset values");

        soft_reset();
        finish_test("soft reset");

        load_program();
        finish_test("program load");

        send_byte(C_RUN);
        while (!cpu_enable) @(negedge clock);
        repeat (run_len) begin
            check_value("cpu_enable in run", 32'(cpu_enable), 32'd1);
            @(negedge clock);
        end
        halt = 1'b1;
        @(negedge clock);
        check_value("cpu_enable after halt", 32'(cpu_enable), 32'd0);
        halt = 1'b0;
        check_dump();
        soft_reset();
        finish_test("continuous run");

        load_program();
        for (int s = 0; s < 2; s++) begin
            enable_cycles = 0;
            send_byte(C_STEP);
            check_dump();
            check_value("step length", 32'(enable_cycles), 32'd1);
        end
        finish_test("single step");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/dbg_top.sv
`default_nettype none

module dbg_top
    import dbg_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_rx_done,
    input  logic [BYTE_W-1:0]      i_rx_data,
    input  logic                   i_soft_reset_ack,
    input  logic                   i_halt,
    input  logic [WORD_W-1:0]      i_reg_data,
    output logic                   o_tx_start,
    output logic [BYTE_W-1:0]      o_tx_data,
    output logic                   o_soft_reset_n,
    output logic                   o_prog_write,
    output logic [PROG_ADDR_W-1:0] o_prog_addr,
    output logic [WORD_W-1:0]      o_prog_data,
    output logic                   o_cpu_enable,
    output logic [REG_ADDR_W-1:0]  o_reg_addr
);

    logic              load_start;
    logic              load_done;
    logic              dump_start;
    logic              dump_done;
    logic              dump_active;
    logic              fsm_tx_start;
    logic [BYTE_W-1:0] fsm_tx_data;
    logic              dump_tx_start;
    logic [BYTE_W-1:0] dump_tx_data;

    rx_byte_if rx_bus ();

    dbg_cmd_decoder i_dbg_cmd_decoder (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx_done (i_rx_done),
        .i_rx_data (i_rx_data),
        .rx        (rx_bus.source)
    );

    dbg_control_fsm i_dbg_control_fsm (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .rx               (rx_bus.sink),
        .i_soft_reset_ack (i_soft_reset_ack),
        .i_halt           (i_halt),
        .i_load_done      (load_done),
        .i_dump_done      (dump_done),
        .o_load_start     (load_start),
        .o_dump_start     (dump_start),
        .o_soft_reset_n   (o_soft_reset_n),
        .o_cpu_enable     (o_cpu_enable),
        .o_tx_start       (fsm_tx_start),
        .o_tx_data        (fsm_tx_data),
        .o_dump_active    (dump_active)
    );

    dbg_program_loader i_dbg_program_loader (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_start      (load_start),
        .rx           (rx_bus.sink),
        .o_prog_write (o_prog_write),
        .o_prog_addr  (o_prog_addr),
        .o_prog_data  (o_prog_data),
        .o_done       (load_done)
    );

    dbg_reg_dump i_dbg_reg_dump (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_start    (dump_start),
        .rx         (rx_bus.sink),
        .i_reg_data (i_reg_data),
        .o_reg_addr (o_reg_addr),
        .o_tx_start (dump_tx_start),
        .o_tx_data  (dump_tx_data),
        .o_done     (dump_done)
    );

    // Dump owns the transmitter only while it runs.
    assign o_tx_start = dump_active ? dump_tx_start : fsm_tx_start;
    assign o_tx_data  = dump_active ? dump_tx_data : fsm_tx_data;

endmodule

`default_nettype wire

//--- hdl/dbg_control_fsm.sv
`default_nettype none

module dbg_control_fsm
    import dbg_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset,
    rx_byte_if.sink           rx,
    input  logic              i_soft_reset_ack,
    input  logic              i_halt,
    input  logic              i_load_done,
    input  logic              i_dump_done,
    output logic              o_load_start,
    output logic              o_dump_start,
    output logic              o_soft_reset_n,
    output logic              o_cpu_enable,
    output logic              o_tx_start,
    output logic [BYTE_W-1:0] o_tx_data,
    output logic              o_dump_active
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        run_step;     // 1 for single step, 0 for continuous.
    logic        is_cmd_run;
    logic        is_cmd_step;

    assign is_cmd_run  = rx.strobe & (rx.cmd == CMD_RUN);
    assign is_cmd_step = rx.strobe & (rx.cmd == CMD_STEP);

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (rx.strobe && rx.cmd == CMD_SOFT_RESET) begin
                    state_next = ST_SOFT_RESET;
                end
            end
            ST_SOFT_RESET: begin
                if (!i_soft_reset_ack) begin    // Processor acknowledges low.
                    state_next = ST_WAIT_LOAD;
                end
            end
            ST_WAIT_LOAD: begin
                if (rx.strobe && rx.cmd == CMD_LOAD) begin
                    state_next = ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (i_load_done) begin
                    state_next = ST_WAIT_START;
                end
            end
            ST_WAIT_START: begin
                if (is_cmd_run || is_cmd_step) begin
                    state_next = ST_RUN;
                end
            end
            ST_RUN: begin
                // A step runs for one clock only.
                if (run_step || i_halt) begin
                    state_next = ST_DUMP;
                end
            end
            ST_DUMP: begin
                if (i_dump_done) begin
                    if (run_step && !i_halt) begin
                        state_next = ST_WAIT_START;  // More steps to come.
                    end else begin
                        state_next = ST_IDLE;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State, run mode and worker start pulses
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state        <= ST_IDLE;
            run_step     <= 1'b0;
            o_load_start <= 1'b0;
            o_dump_start <= 1'b0;
        end else begin
            state        <= state_next;
            o_load_start <= (state == ST_WAIT_LOAD) && (state_next == ST_LOAD);
            o_dump_start <= (state == ST_RUN) && (state_next == ST_DUMP);
            if (state == ST_WAIT_START && (is_cmd_run || is_cmd_step)) begin
                run_step <= is_cmd_step;
            end
        end
    end

    assign o_soft_reset_n = (state != ST_SOFT_RESET);  // Active low.
    assign o_cpu_enable   = (state == ST_RUN);
    assign o_dump_active  = (state == ST_DUMP);

    // Ready byte stays up until the load command arrives.
    assign o_tx_start = (state == ST_WAIT_LOAD);
    assign o_tx_data  = o_tx_start ? READY_BYTE : '0;

endmodule

`default_nettype wire

//--- hdl/dbg_reg_dump.sv
`default_nettype none

module dbg_reg_dump
    import dbg_pkg::*;
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_start,
    rx_byte_if.sink               rx,
    input  logic [WORD_W-1:0]     i_reg_data,
    output logic [REG_ADDR_W-1:0] o_reg_addr,
    output logic                  o_tx_start,
    output logic [BYTE_W-1:0]     o_tx_data,
    output logic                  o_done
);

    logic                  active;
    logic                  end_phase;   // END_BYTE is on the port.
    logic [REG_ADDR_W-1:0] reg_idx;
    logic [BYTE_IDX_W-1:0] byte_idx;    // 0 is the most significant byte.
    logic                  ack;
    logic                  last_reg;
    logic                  last_byte;
    int                    sel_lsb;

    assign ack        = active & rx.strobe & rx.is_ack;
    assign last_reg   = (reg_idx == REG_ADDR_W'(NUM_REGS - 1));
    assign last_byte  = (byte_idx == BYTE_IDX_W'(BYTES_PER_WORD - 1));
    assign o_reg_addr = reg_idx;
    assign o_tx_start = active;     // Held until the host acknowledges.

    ////////////////////////////////////////////////////////////
    // Byte selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        sel_lsb = (BYTES_PER_WORD - 1 - int'(byte_idx)) * BYTE_W;
        if (end_phase) begin
            o_tx_data = END_BYTE;
        end else begin
            o_tx_data = i_reg_data[sel_lsb +: BYTE_W];
        end
    end

    ////////////////////////////////////////////////////////////
    // Register and byte counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            active    <= 1'b0;
            end_phase <= 1'b0;
            reg_idx   <= '0;
            byte_idx  <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                active    <= 1'b1;
                end_phase <= 1'b0;
                reg_idx   <= '0;
                byte_idx  <= '0;
            end else if (ack) begin
                if (end_phase) begin
                    active    <= 1'b0;     // End code acknowledged.
                    end_phase <= 1'b0;
                    o_done    <= 1'b1;
                end else if (last_byte) begin
                    byte_idx <= '0;
                    if (last_reg) begin
                        end_phase <= 1'b1;
                    end else begin
                        reg_idx <= reg_idx + 1'b1;
                    end
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dbg_program_loader.sv
`default_nettype none

module dbg_program_loader
    import dbg_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_start,
    rx_byte_if.sink                rx,
    output logic                   o_prog_write,
    output logic [PROG_ADDR_W-1:0] o_prog_addr,
    output logic [WORD_W-1:0]      o_prog_data,
    output logic                   o_done
);

    logic                  active;
    logic [BYTE_IDX_W-1:0] byte_cnt;    // Bytes already in this word.
    logic [WORD_W-1:0]     instr;
    logic [WORD_W-1:0]     instr_next;
    logic                  last_byte;
    logic                  take;

    // Most significant byte arrives first.
    assign instr_next  = {instr[WORD_W-BYTE_W-1:0], rx.data};
    assign last_byte   = (byte_cnt == BYTE_IDX_W'(BYTES_PER_WORD - 1));
    assign take        = active & rx.strobe;
    assign o_prog_data = instr;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            active       <= 1'b0;
            byte_cnt     <= '0;
            o_prog_addr  <= '0;
            o_prog_write <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            o_prog_write <= 1'b0;
            o_done       <= 1'b0;

            if (o_prog_write) begin
                o_prog_addr <= o_prog_addr + 1'b1;    // Next word slot.
            end

            if (i_start) begin
                active      <= 1'b1;
                byte_cnt    <= '0;
                o_prog_addr <= '0;
            end else if (take) begin
                if (last_byte) begin
                    byte_cnt <= '0;
                    if (instr_next == HALT_WORD) begin
                        active <= 1'b0;    // HALT itself is never written.
                        o_done <= 1'b1;
                    end else begin
                        o_prog_write <= 1'b1;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction shift register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (take) begin
            instr <= instr_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dbg_cmd_decoder.sv
`default_nettype none

module dbg_cmd_decoder
    import dbg_pkg::*;
(
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_rx_done,
    input  logic [BYTE_W-1:0] i_rx_data,
    rx_byte_if.source         rx
);

    logic              done_q;     // Latest sample of the done flag.
    logic              done_qq;    // Sample before that.
    logic [BYTE_W-1:0] data_q;     // Byte sampled with done_q.
    logic              fall;
    cmd_e              cmd_next;

    // High for one cycle after the done flag is first sampled low.
    assign fall = done_qq & ~done_q;

    always_comb begin
        case (data_q)
            CMD_SOFT_RESET: cmd_next = CMD_SOFT_RESET;
            CMD_LOAD:       cmd_next = CMD_LOAD;
            CMD_RUN:        cmd_next = CMD_RUN;
            CMD_STEP:       cmd_next = CMD_STEP;
            CMD_ACK:        cmd_next = CMD_ACK;
            default:        cmd_next = CMD_NONE;  // Program bytes land here.
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            done_q    <= 1'b0;
            done_qq   <= 1'b0;
            rx.strobe <= 1'b0;
        end else begin
            done_q    <= i_rx_done;
            done_qq   <= done_q;
            rx.strobe <= fall;
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte capture and classification
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        data_q <= i_rx_data;
        if (fall) begin
            rx.data   <= data_q;
            rx.cmd    <= cmd_next;
            rx.is_ack <= (cmd_next == CMD_ACK);
        end
    end

endmodule

`default_nettype wire

//--- hdl/rx_byte_if.sv
`default_nettype none

interface rx_byte_if
    import dbg_pkg::*;
();

    logic              strobe;  // One cycle per received byte.
    logic [BYTE_W-1:0] data;
    cmd_e              cmd;
    logic              is_ack;  // Same as cmd == CMD_ACK.

    modport source (
        output strobe, data, cmd, is_ack
    );

    modport sink (
        input strobe, data, cmd, is_ack
    );

endinterface

`default_nettype wire

//--- hdl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int BYTE_W         = 8;                          // UART byte.
    localparam int WORD_W         = 32;                         // Instruction and register word.
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_IDX_W     = $clog2(BYTES_PER_WORD);     // Byte index within a word.
    localparam int PROG_ADDR_W    = 10;                         // Program memory word address.
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_REGS       = 32;

    ////////////////////////////////////////////////////////////
    // Protocol constants
    ////////////////////////////////////////////////////////////

    localparam logic [WORD_W-1:0] HALT_WORD  = '1;      // Ends a program load.
    localparam logic [BYTE_W-1:0] READY_BYTE = 8'h01;   // Sent once the processor is reset.
    localparam logic [BYTE_W-1:0] END_BYTE   = 8'h0B;   // Closes a register dump.

    // Host command bytes. Anything not listed decodes to CMD_NONE.
    typedef enum logic [BYTE_W-1:0] {
        CMD_SOFT_RESET = 8'h00,
        CMD_LOAD       = 8'h01,
        CMD_RUN        = 8'h03,
        CMD_STEP       = 8'h07,
        CMD_ACK        = 8'h08,
        CMD_NONE       = 8'hFF
    } cmd_e;

    // Control states, one-hot.
    typedef enum logic [6:0] {
        ST_IDLE       = 7'b0000001,
        ST_SOFT_RESET = 7'b0000010,
        ST_WAIT_LOAD  = 7'b0000100,
        ST_LOAD       = 7'b0001000,
        ST_WAIT_START = 7'b0010000,
        ST_RUN        = 7'b0100000,
        ST_DUMP       = 7'b1000000
    } ctrl_state_e;

endpackage

`default_nettype wire
